// ==== tb.f ====
+incdir+hw
hw/sq_pkg.sv
hw/sq_ctrl.sv
hw/sq_entry_array.sv
hw/sq_forward.sv
hw/store_queue_top.sv
verification/sq_props.sv
verification/sq_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the store queue testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module sq_tb -f tb.f -Mdir obj_dir -o sq_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sq_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation exited cleanly"
exit 0

// ==== verification/sq_tb.sv ====
`include "sq_defines.svh"

module sq_tb
  import sq_pkg::*;
();

  localparam int SQ_SIZE       = `SQ_SIZE;
  localparam int RANDOM_CYCLES = 2000;
  // twice the random phase, leaves room for reset and the final drain
  localparam int MAX_CYCLES    = 4000;

  logic      clock;
  logic      reset;
  logic      enq_valid;
  sq_enq_t   enq;
  logic      full;
  logic      data_valid;
  sq_data_t  data;
  logic      commit_valid;
  rob_idx_t  commit_rob_idx;
  ld_query_t ld_query;
  fwd_resp_t fwd;
  logic      dc_req_valid;
  dc_req_t   dc_req;
  logic      dc_req_accept;
  logic      branch;
  logic      restore;

  integer seed;
  int     cycles = 0;

  // ==================================================
  // reference model state
  // ==================================================

  sq_entry_t m_ent [SQ_SIZE];
  // slot enqueued after the live checkpoint
  logic      m_young [SQ_SIZE];
  int        m_head;
  int        m_tail;
  int        m_count;
  logic      m_ckpt_valid;
  int        m_ckpt_tail;
  // a younger store got committed, restore no longer legal
  logic      m_young_committed;
  rob_idx_t  next_rob;

  store_queue_top store_queue_top_inst (
    .clock_i          (clock),
    .reset_i          (reset),
    .enq_valid_i      (enq_valid),
    .enq_i            (enq),
    .full_o           (full),
    .data_valid_i     (data_valid),
    .data_i           (data),
    .commit_valid_i   (commit_valid),
    .commit_rob_idx_i (commit_rob_idx),
    .ld_query_i       (ld_query),
    .fwd_o            (fwd),
    .dc_req_valid_o   (dc_req_valid),
    .dc_req_o         (dc_req),
    .dc_req_accept_i  (dc_req_accept),
    .branch_i         (branch),
    .restore_i        (restore)
  );

  initial begin
    clock = 1'b0;
  end

  always #50 clock = ~clock;

  // run length guard
  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("*** FAILED ***");
      $fatal(1, "timeout, the run did not finish within %0d cycles", MAX_CYCLES);
    end
  end

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] time %0t %s expected %h actual %h", $time, name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "output mismatch on %s", name);
    end
  endtask

  function automatic int ring_index(input int v);
    return ((v % SQ_SIZE) + SQ_SIZE) % SQ_SIZE;
  endfunction

  function automatic logic rob_in_use(input rob_idx_t r);
    logic used;
    used = 1'b0;
    for (int i = 0; i < SQ_SIZE; i++) begin
      if (m_ent[i].valid && (m_ent[i].rob_idx == r)) begin
        used = 1'b1;
      end
    end
    return used;
  endfunction

  // counter value, skipping any index still live
  function automatic rob_idx_t fresh_rob();
    rob_idx_t r;
    while (rob_in_use(next_rob)) begin
      next_rob = next_rob + 1'b1;
    end
    r = next_rob;
    next_rob = next_rob + 1'b1;
    return r;
  endfunction

  // youngest live store first, stop at the first overlap
  function automatic fwd_resp_t model_forward(input ld_query_t q);
    fwd_resp_t r;
    logic      found;
    int        idx;
    r     = '0;
    found = 1'b0;
    for (int k = 1; k <= m_count; k++) begin
      idx = ring_index(m_tail - k);
      if (!found && ranges_overlap(m_ent[idx].addr, m_ent[idx].size, q.addr, q.size)) begin
        found = 1'b1;
        if (m_ent[idx].data_valid) begin
          r.valid = 1'b1;
          r.addr  = m_ent[idx].addr;
          r.data  = m_ent[idx].data;
        end else begin
          r.pending = 1'b1;
        end
      end
    end
    return r;
  endfunction

  task automatic model_reset();
    for (int i = 0; i < SQ_SIZE; i++) begin
      m_ent[i]   = '0;
      m_young[i] = 1'b0;
    end
    m_head            = 0;
    m_tail            = 0;
    m_count           = 0;
    m_ckpt_valid      = 1'b0;
    m_ckpt_tail       = 0;
    m_young_committed = 1'b0;
    next_rob          = '0;
  endtask

  // ==================================================
  // model update at the rising edge
  // ==================================================

  task automatic model_step();
    logic do_restore;
    logic do_pop;
    logic do_enq;
    logic found;
    int   idx;
    do_restore = restore && m_ckpt_valid;
    do_pop = m_ent[m_head].valid && m_ent[m_head].committed && m_ent[m_head].data_valid
          && !do_restore && dc_req_accept;
    do_enq = enq_valid && (m_count < SQ_SIZE) && !do_restore;
    if (do_restore) begin
      // drop every store enqueued after the branch
      for (int i = 0; i < SQ_SIZE; i++) begin
        if (m_ent[i].valid && m_young[i]) begin
          m_ent[i] = '0;
          m_count  = m_count - 1;
        end
        m_young[i] = 1'b0;
      end
      m_tail       = m_ckpt_tail;
      m_ckpt_valid = 1'b0;
      return;
    end
    // commit sees the data flag from before this edge
    if (commit_valid) begin
      found = 1'b0;
      for (int k = 0; k < m_count; k++) begin
        idx = ring_index(m_head + k);
        if (!found && (m_ent[idx].rob_idx == commit_rob_idx)) begin
          found = 1'b1;
          if (m_ent[idx].data_valid) begin
            m_ent[idx].committed = 1'b1;
            if (m_young[idx]) begin
              m_young_committed = 1'b1;
            end
          end
        end
      end
    end
    if (data_valid) begin
      found = 1'b0;
      for (int k = 0; k < m_count; k++) begin
        idx = ring_index(m_head + k);
        if (!found && (m_ent[idx].rob_idx == data.rob_idx)) begin
          found = 1'b1;
          m_ent[idx].data_valid = 1'b1;
          m_ent[idx].data       = data.data;
        end
      end
    end
    if (do_pop) begin
      m_ent[m_head]   = '0;
      m_young[m_head] = 1'b0;
      m_head          = ring_index(m_head + 1);
      m_count         = m_count - 1;
    end
    // live stores become older than the new checkpoint
    if (branch) begin
      m_ckpt_valid      = 1'b1;
      m_ckpt_tail       = m_tail;
      m_young_committed = 1'b0;
      for (int i = 0; i < SQ_SIZE; i++) begin
        m_young[i] = 1'b0;
      end
    end
    if (do_enq) begin
      m_ent[m_tail]         = '0;
      m_ent[m_tail].valid   = 1'b1;
      m_ent[m_tail].addr    = enq.addr;
      m_ent[m_tail].size    = enq.size;
      m_ent[m_tail].rob_idx = enq.rob_idx;
      m_young[m_tail]       = m_ckpt_valid;
      m_tail                = ring_index(m_tail + 1);
      m_count               = m_count + 1;
    end
  endtask

  // ==================================================
  // stimulus
  // ==================================================

  task automatic drive_idle();
    enq_valid      = 1'b0;
    enq            = '0;
    data_valid     = 1'b0;
    data           = '0;
    commit_valid   = 1'b0;
    commit_rob_idx = '0;
    ld_query       = '0;
    dc_req_accept  = 1'b0;
    branch         = 1'b0;
    restore        = 1'b0;
  endtask

  // drain mode: nothing new enters, data and commits flow, cache always accepts
  task automatic drive_inputs(input logic drain);
    int cands [$];
    int idx;
    int oldest;
    drive_idle();
    dc_req_accept = drain ? 1'b1 : ($random(seed) & 1);
    // narrow address window so loads often hit stores
    ld_query.addr = 32'h100 + ($random(seed) & 32'h1f);
    ld_query.size = mem_size_e'($random(seed) & 3);
    if (!drain && m_ckpt_valid && !m_young_committed && (($random(seed) & 31) == 0)) begin
      restore = 1'b1;
      return;
    end
    if (!drain && (($random(seed) & 31) == 0)) begin
      branch = 1'b1;
    end
    if (!drain && (m_count < SQ_SIZE) && (($random(seed) & 1) == 1)) begin
      enq_valid   = 1'b1;
      enq.addr    = 32'h100 + ($random(seed) & 32'h1f);
      enq.size    = mem_size_e'($random(seed) & 3);
      enq.rob_idx = fresh_rob();
    end
    // data for any live store still waiting on it
    for (int k = 0; k < m_count; k++) begin
      idx = ring_index(m_head + k);
      if (!m_ent[idx].data_valid) begin
        cands.push_back(idx);
      end
    end
    if ((cands.size() > 0) && (drain || (($random(seed) & 1) == 1))) begin
      idx          = cands[($random(seed) & 32'h7fff) % cands.size()];
      data_valid   = 1'b1;
      data.rob_idx = m_ent[idx].rob_idx;
      data.data    = {$random(seed), $random(seed)};
    end
    // commits go in order, oldest uncommitted only
    oldest = -1;
    for (int k = m_count - 1; k >= 0; k--) begin
      idx = ring_index(m_head + k);
      if (!m_ent[idx].committed) begin
        oldest = idx;
      end
    end
    if (oldest >= 0) begin
      if (m_ent[oldest].data_valid && (drain || (($random(seed) & 1) == 1))) begin
        commit_valid   = 1'b1;
        commit_rob_idx = m_ent[oldest].rob_idx;
      end else if (!m_ent[oldest].data_valid && (($random(seed) & 7) == 0)) begin
        // early commit, must be ignored
        commit_valid   = 1'b1;
        commit_rob_idx = m_ent[oldest].rob_idx;
      end
    end
  endtask

  task automatic check_outputs();
    fwd_resp_t exp_fwd;
    logic      exp_req;
    exp_fwd = model_forward(ld_query);
    exp_req = m_ent[m_head].valid && m_ent[m_head].committed && m_ent[m_head].data_valid
           && !(restore && m_ckpt_valid);
    check_value("full_o", (m_count == SQ_SIZE), full);
    check_value("fwd_o.valid", exp_fwd.valid, fwd.valid);
    check_value("fwd_o.pending", exp_fwd.pending, fwd.pending);
    if (exp_fwd.valid) begin
      check_value("fwd_o.addr", exp_fwd.addr, fwd.addr);
      check_value("fwd_o.data", exp_fwd.data, fwd.data);
    end
    check_value("dc_req_valid_o", exp_req, dc_req_valid);
    if (exp_req) begin
      check_value("dc_req_o.addr", m_ent[m_head].addr, dc_req.addr);
      check_value("dc_req_o.size", m_ent[m_head].size, dc_req.size);
      check_value("dc_req_o.cmd", MEM_STORE, dc_req.cmd);
      check_value("dc_req_o.data", m_ent[m_head].data, dc_req.data);
    end
  endtask

  // ==================================================
  // main sequence
  // ==================================================

  initial begin
    seed  = 32'he71c;
    reset = 1'b1;
    drive_idle();
    model_reset();
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      @(negedge clock);
      drive_inputs(1'b0);
      #1;
      check_outputs();
      @(posedge clock);
      model_step();
    end
    // empty the queue, bounded by the cycle guard
    while (m_count != 0) begin
      @(negedge clock);
      drive_inputs(1'b1);
      #1;
      check_outputs();
      @(posedge clock);
      model_step();
    end
    @(negedge clock);
    drive_idle();
    #1;
    check_outputs();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== verification/sq_props.sv ====
`include "sq_defines.svh"

module sq_props
  import sq_pkg::*;
(
  input logic                     clock_i,
  input logic                     reset_i,
  input logic                     full_i,
  input logic                     enq_we_i,
  input sq_idx_t                  enq_idx_i,
  input sq_entry_t [`SQ_SIZE-1:0] entries_i,
  input ld_query_t                ld_query_i,
  input fwd_resp_t                fwd_i,
  input logic                     dc_req_valid_i
);

  // ==================================================
  // occupancy
  // ==================================================

  // no slot written while every slot is taken
  // the tail slot must be free when it is written
  full_never_written: assert property (
    @(posedge clock_i) disable iff (reset_i)
      enq_we_i |-> !full_i && !entries_i[enq_idx_i].valid
  ) else $error("enqueue written into a full queue or an occupied slot");

  // ==================================================
  // output consistency
  // ==================================================

  // forward result is either data or a stall, never both
  // forwarded store must overlap the load
  // its bytes lie inside a double at its address
  fwd_one_kind: assert property (
    @(posedge clock_i) disable iff (reset_i)
      fwd_i.valid |-> !fwd_i.pending
                    && ranges_overlap(fwd_i.addr, DOUBLE, ld_query_i.addr, ld_query_i.size)
  ) else $error("forward response inconsistent with the load query");

  // state is cleared by every reset edge, so no store leaves
  no_req_in_reset: assert property (
    @(posedge clock_i) reset_i |=> !dc_req_valid_i
  ) else $error("cache request raised during reset");

endmodule

bind store_queue_top sq_props sq_props_inst (
  .clock_i        (clock_i),
  .reset_i        (reset_i),
  .full_i         (full_o),
  .enq_we_i       (enq_we),
  .enq_idx_i      (enq_idx),
  .entries_i      (entries),
  .ld_query_i     (ld_query_i),
  .fwd_i          (fwd_o),
  .dc_req_valid_i (dc_req_valid_o)
);

// ==== hw/store_queue_top.sv ====
`include "sq_defines.svh"

module store_queue_top
  import sq_pkg::*;
(
  input  logic      clock_i,
  input  logic      reset_i,
  // dispatch
  input  logic      enq_valid_i,
  input  sq_enq_t   enq_i,
  output logic      full_o,
  // store data
  input  logic      data_valid_i,
  input  sq_data_t  data_i,
  // rob commit
  input  logic      commit_valid_i,
  input  rob_idx_t  commit_rob_idx_i,
  // load forwarding
  input  ld_query_t ld_query_i,
  output fwd_resp_t fwd_o,
  // data cache
  output logic      dc_req_valid_o,
  output dc_req_t   dc_req_o,
  input  logic      dc_req_accept_i,
  // branch checkpoint and restore
  input  logic      branch_i,
  input  logic      restore_i
);

  // ctrl to array
  logic    enq_we;
  sq_idx_t enq_idx;
  logic    pop;
  sq_idx_t head_idx;
  sq_idx_t tail_idx;
  logic    restore_valid;
  sq_idx_t restore_tail;
  sq_cnt_t restore_count;

  // array to ctrl and forward
  sq_entry_t                head_entry;
  sq_entry_t [`SQ_SIZE-1:0] entries;

  // ==================================================
  // pointers, checkpoint, cache request
  // ==================================================

  sq_ctrl sq_ctrl_inst (
    .clock_i         (clock_i),
    .reset_i         (reset_i),
    .enq_valid_i     (enq_valid_i),
    .branch_i        (branch_i),
    .restore_i       (restore_i),
    .dc_req_accept_i (dc_req_accept_i),
    .head_entry_i    (head_entry),
    .full_o          (full_o),
    .enq_we_o        (enq_we),
    .enq_idx_o       (enq_idx),
    .pop_o           (pop),
    .head_idx_o      (head_idx),
    .tail_idx_o      (tail_idx),
    .restore_valid_o (restore_valid),
    .restore_tail_o  (restore_tail),
    .restore_count_o (restore_count),
    .dc_req_valid_o  (dc_req_valid_o),
    .dc_req_o        (dc_req_o)
  );

  // ==================================================
  // slot storage
  // ==================================================

  sq_entry_array sq_entry_array_inst (
    .clock_i          (clock_i),
    .reset_i          (reset_i),
    .enq_we_i         (enq_we),
    .enq_idx_i        (enq_idx),
    .enq_i            (enq_i),
    .data_valid_i     (data_valid_i),
    .data_i           (data_i),
    .commit_valid_i   (commit_valid_i),
    .commit_rob_idx_i (commit_rob_idx_i),
    .pop_i            (pop),
    .head_idx_i       (head_idx),
    .restore_valid_i  (restore_valid),
    .restore_tail_i   (restore_tail),
    .restore_count_i  (restore_count),
    .entries_o        (entries),
    .head_entry_o     (head_entry)
  );

  // load forwarding, combinational
  sq_forward sq_forward_inst (
    .entries_i  (entries),
    .tail_idx_i (tail_idx),
    .ld_query_i (ld_query_i),
    .fwd_o      (fwd_o)
  );

endmodule

// ==== hw/sq_forward.sv ====
`include "sq_defines.svh"

module sq_forward
  import sq_pkg::*;
(
  input  sq_entry_t [`SQ_SIZE-1:0] entries_i,
  // first free slot, youngest store sits just below it
  input  sq_idx_t                  tail_idx_i,
  input  ld_query_t                ld_query_i,
  output fwd_resp_t                fwd_o
);

  // per slot overlap with the load
  logic [`SQ_SIZE-1:0] overlap;

  // youngest overlapping store
  logic    hit;
  sq_idx_t hit_idx;

  sq_entry_t hit_entry;

  // ==================================================
  // overlap per slot
  // ==================================================

  always_comb begin
    for (int i = 0; i < `SQ_SIZE; i++) begin
      overlap[i] = entries_i[i].valid
                && ranges_overlap(entries_i[i].addr, entries_i[i].size,
                                  ld_query_i.addr, ld_query_i.size);
    end
  end

  // ==================================================
  // youngest first scan
  // ==================================================

  // tail-1 down to tail-SQ_SIZE, the last step lands on tail itself
  // which is the oldest slot when the queue is full
  always_comb begin
    sq_idx_t idx;
    hit     = 1'b0;
    hit_idx = '0;
    for (int k = 1; k <= `SQ_SIZE; k++) begin
      idx = tail_idx_i - sq_idx_t'(k);
      if (!hit && overlap[idx]) begin
        hit     = 1'b1;
        hit_idx = idx;
      end
    end
  end

  assign hit_entry = entries_i[hit_idx];

  // ==================================================
  // response
  // ==================================================

  // whole word and address, no byte merge
  always_comb begin
    fwd_o = '0;
    if (hit) begin
      if (hit_entry.data_valid) begin
        fwd_o.valid = 1'b1;
        fwd_o.addr  = hit_entry.addr;
        fwd_o.data  = hit_entry.data;
      end else begin
        // youngest match still waits for data, load must stall
        fwd_o.pending = 1'b1;
      end
    end
  end

endmodule

// ==== hw/sq_entry_array.sv ====
`include "sq_defines.svh"

module sq_entry_array
  import sq_pkg::*;
(
  input  logic                       clock_i,
  input  logic                       reset_i,
  // new slot at the tail
  input  logic                       enq_we_i,
  input  sq_idx_t                    enq_idx_i,
  input  sq_enq_t                    enq_i,
  // late data, found by rob index
  input  logic                       data_valid_i,
  input  sq_data_t                   data_i,
  // rob commit, found by rob index
  input  logic                       commit_valid_i,
  input  rob_idx_t                   commit_rob_idx_i,
  // retirement of the head slot
  input  logic                       pop_i,
  input  sq_idx_t                    head_idx_i,
  // squash of everything past the saved tail
  input  logic                       restore_valid_i,
  input  sq_idx_t                    restore_tail_i,
  input  sq_cnt_t                    restore_count_i,
  output sq_entry_t [`SQ_SIZE-1:0]   entries_o,
  output sq_entry_t                  head_entry_o
);

  // per slot flags
  logic [`SQ_SIZE-1:0] valid_q;
  logic [`SQ_SIZE-1:0] data_valid_q;
  logic [`SQ_SIZE-1:0] committed_q;

  // per slot payload
  sq_addr_t  addr_q [`SQ_SIZE];
  mem_size_e size_q [`SQ_SIZE];
  rob_idx_t  rob_q  [`SQ_SIZE];
  sq_word_t  data_q [`SQ_SIZE];

  logic    fill_hit;
  sq_idx_t fill_idx;
  logic    commit_hit;
  sq_idx_t commit_idx;

  logic [`SQ_SIZE-1:0] keep;

  // ==================================================
  // rob index search, oldest first from head
  // ==================================================

  always_comb begin
    sq_idx_t idx;
    fill_hit   = 1'b0;
    fill_idx   = '0;
    commit_hit = 1'b0;
    commit_idx = '0;
    for (int k = 0; k < `SQ_SIZE; k++) begin
      idx = head_idx_i + sq_idx_t'(k);
      if (!fill_hit && valid_q[idx] && (rob_q[idx] == data_i.rob_idx)) begin
        fill_hit = 1'b1;
        fill_idx = idx;
      end
      if (!commit_hit && valid_q[idx] && (rob_q[idx] == commit_rob_idx_i)) begin
        commit_hit = 1'b1;
        commit_idx = idx;
      end
    end
  end

  // surviving window is head up to the saved tail
  // full count means the window wraps all the way round
  always_comb begin
    sq_idx_t off_i;
    sq_idx_t off_tail;
    off_tail = restore_tail_i - head_idx_i;
    for (int i = 0; i < `SQ_SIZE; i++) begin
      off_i   = sq_idx_t'(i) - head_idx_i;
      keep[i] = (restore_count_i == sq_cnt_t'(`SQ_SIZE)) || (off_i < off_tail);
    end
  end

  // ==================================================
  // flag update
  // ==================================================

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      valid_q      <= '0;
      data_valid_q <= '0;
      committed_q  <= '0;
    end else if (restore_valid_i) begin
      valid_q      <= valid_q & keep;
      data_valid_q <= data_valid_q & keep;
      committed_q  <= committed_q & keep;
    end else begin
      if (enq_we_i) begin
        valid_q[enq_idx_i]      <= 1'b1;
        data_valid_q[enq_idx_i] <= 1'b0;
        committed_q[enq_idx_i]  <= 1'b0;
      end
      if (data_valid_i && fill_hit) begin
        data_valid_q[fill_idx] <= 1'b1;
      end
      // commit without data is dropped
      if (commit_valid_i && commit_hit && data_valid_q[commit_idx]) begin
        committed_q[commit_idx] <= 1'b1;
      end
      if (pop_i) begin
        valid_q[head_idx_i]      <= 1'b0;
        data_valid_q[head_idx_i] <= 1'b0;
        committed_q[head_idx_i]  <= 1'b0;
      end
    end
  end

  // payload, only meaningful under the flags
  always_ff @(posedge clock_i) begin
    if (enq_we_i) begin
      addr_q[enq_idx_i] <= enq_i.addr;
      size_q[enq_idx_i] <= enq_i.size;
      rob_q[enq_idx_i]  <= enq_i.rob_idx;
    end
    if (data_valid_i && fill_hit && !restore_valid_i) begin
      data_q[fill_idx] <= data_i.data;
    end
  end

  always_comb begin
    for (int i = 0; i < `SQ_SIZE; i++) begin
      entries_o[i].valid      = valid_q[i];
      entries_o[i].addr       = addr_q[i];
      entries_o[i].size       = size_q[i];
      entries_o[i].rob_idx    = rob_q[i];
      entries_o[i].data_valid = data_valid_q[i];
      entries_o[i].data       = data_q[i];
      entries_o[i].committed  = committed_q[i];
    end
  end

  assign head_entry_o = entries_o[head_idx_i];

endmodule

// ==== hw/sq_ctrl.sv ====
`include "sq_defines.svh"

module sq_ctrl
  import sq_pkg::*;
(
  input  logic      clock_i,
  input  logic      reset_i,
  // dispatch and branch control
  input  logic      enq_valid_i,
  input  logic      branch_i,
  input  logic      restore_i,
  // cache side
  input  logic      dc_req_accept_i,
  // current head slot from the array
  input  sq_entry_t head_entry_i,
  output logic      full_o,
  // array write and retire strobes
  output logic      enq_we_o,
  output sq_idx_t   enq_idx_o,
  output logic      pop_o,
  output sq_idx_t   head_idx_o,
  output sq_idx_t   tail_idx_o,
  // squash request toward the array
  output logic      restore_valid_o,
  output sq_idx_t   restore_tail_o,
  output sq_cnt_t   restore_count_o,
  // store request to the data cache
  output logic      dc_req_valid_o,
  output dc_req_t   dc_req_o
);

  // ring state
  sq_idx_t head_q;
  sq_idx_t tail_q;
  sq_cnt_t count_q;

  // single branch checkpoint
  logic    ckpt_valid_q;
  sq_idx_t ckpt_tail_q;
  sq_cnt_t ckpt_count_q;

  logic head_ready;

  // ==================================================
  // strobes
  // ==================================================

  assign full_o     = (count_q == sq_cnt_t'(`SQ_SIZE));
  assign head_idx_o = head_q;
  assign tail_idx_o = tail_q;
  assign enq_idx_o  = tail_q;

  // restore only acts when a checkpoint is held
  assign restore_valid_o = restore_i && ckpt_valid_q;
  assign restore_tail_o  = ckpt_tail_q;
  // older stores still in the queue, same as head to saved tail distance
  // tracked as a count so a full window is not mistaken for an empty one
  assign restore_count_o = ckpt_count_q;

  // head leaves once it is committed and has its data
  assign head_ready = head_entry_i.valid && head_entry_i.committed && head_entry_i.data_valid;

  // restore owns the cycle, so no request and no retirement then
  assign dc_req_valid_o = head_ready && !restore_valid_o;
  assign pop_o          = dc_req_valid_o && dc_req_accept_i;

  // enqueue while full is dropped
  assign enq_we_o = enq_valid_i && !full_o && !restore_valid_o;

  // payload straight off the head slot, stable until it retires
  always_comb begin
    dc_req_o.addr = head_entry_i.addr;
    dc_req_o.size = head_entry_i.size;
    dc_req_o.cmd  = MEM_STORE;
    dc_req_o.data = head_entry_i.data;
  end

  // ==================================================
  // pointers and count
  // ==================================================

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (restore_valid_o) begin
      // roll tail back, head stays where it is
      tail_q  <= ckpt_tail_q;
      count_q <= ckpt_count_q;
    end else begin
      if (enq_we_o) begin
        tail_q <= tail_q + 1'b1;
      end
      if (pop_o) begin
        head_q <= head_q + 1'b1;
      end
      case ({enq_we_o, pop_o})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // checkpoint, enqueue in the branch cycle counts as younger
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      ckpt_valid_q <= 1'b0;
      ckpt_tail_q  <= '0;
      ckpt_count_q <= '0;
    end else if (restore_valid_o) begin
      ckpt_valid_q <= 1'b0;
    end else if (branch_i) begin
      ckpt_valid_q <= 1'b1;
      ckpt_tail_q  <= tail_q;
      ckpt_count_q <= count_q - sq_cnt_t'(pop_o);
    end else if (pop_o && (ckpt_count_q != '0)) begin
      // older stores drain first, shrink the surviving window
      ckpt_count_q <= ckpt_count_q - 1'b1;
    end
  end

endmodule

// ==== hw/sq_pkg.sv ====
`include "sq_defines.svh"

package sq_pkg;

  // access size, log2 of the byte count
  typedef enum logic [1:0] {
    BYTE   = 2'd0,
    HALF   = 2'd1,
    WORD   = 2'd2,
    DOUBLE = 2'd3
  } mem_size_e;

  // cache command, the queue only ever issues stores
  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_cmd_e;

  // scalar field types
  typedef logic [`SQ_IDX_W-1:0]  sq_idx_t;
  typedef logic [`SQ_CNT_W-1:0]  sq_cnt_t;
  typedef logic [`SQ_ADDR_W-1:0] sq_addr_t;
  typedef logic [`SQ_DATA_W-1:0] sq_word_t;
  typedef logic [`SQ_ROB_W-1:0]  rob_idx_t;

  // ==================================================
  // bundles
  // ==================================================

  // dispatch side, address known at enqueue
  typedef struct packed {
    sq_addr_t  addr;
    mem_size_e size;
    rob_idx_t  rob_idx;
  } sq_enq_t;

  // late store data, tagged by rob index
  typedef struct packed {
    rob_idx_t rob_idx;
    sq_word_t data;
  } sq_data_t;

  typedef struct packed {
    sq_addr_t  addr;
    mem_size_e size;
  } ld_query_t;

  // one queue slot
  typedef struct packed {
    logic      valid;
    sq_addr_t  addr;
    mem_size_e size;
    rob_idx_t  rob_idx;
    logic      data_valid;
    sq_word_t  data;
    logic      committed;
  } sq_entry_t;

  // pending means an overlapping store exists without its data
  typedef struct packed {
    logic     valid;
    logic     pending;
    sq_addr_t addr;
    sq_word_t data;
  } fwd_resp_t;

  typedef struct packed {
    sq_addr_t  addr;
    mem_size_e size;
    mem_cmd_e  cmd;
    sq_word_t  data;
  } dc_req_t;

  // ==================================================
  // helpers
  // ==================================================

  function automatic logic [3:0] access_bytes(input mem_size_e size);
    case (size)
      BYTE:    return 4'd1;
      HALF:    return 4'd2;
      WORD:    return 4'd4;
      default: return 4'd8;
    endcase
  endfunction

  // overlap unless one range ends before the other starts
  // one extra bit so a range at the top of memory does not wrap
  function automatic logic ranges_overlap(input sq_addr_t a_addr, input mem_size_e a_size,
                                          input sq_addr_t b_addr, input mem_size_e b_size);
    logic [`SQ_ADDR_W:0] a_lo;
    logic [`SQ_ADDR_W:0] a_hi;
    logic [`SQ_ADDR_W:0] b_lo;
    logic [`SQ_ADDR_W:0] b_hi;
    a_lo = {1'b0, a_addr};
    b_lo = {1'b0, b_addr};
    // last byte = first byte + size - 1
    a_hi = a_lo + {{(`SQ_ADDR_W - 3){1'b0}}, access_bytes(a_size) - 4'd1};
    b_hi = b_lo + {{(`SQ_ADDR_W - 3){1'b0}}, access_bytes(b_size) - 4'd1};
    return !((a_hi < b_lo) || (b_hi < a_lo));
  endfunction

endpackage

// ==== hw/sq_defines.svh ====
`ifndef SQ_DEFINES_SVH
`define SQ_DEFINES_SVH

// ==================================================
// queue geometry
// ==================================================

// number of store queue entries
// keep a power of two, ring offsets wrap on their own
`define SQ_SIZE 8

// ring pointer width
`define SQ_IDX_W ($clog2(`SQ_SIZE))

// occupancy count, must be able to hold SQ_SIZE itself
`define SQ_CNT_W ($clog2(`SQ_SIZE + 1))

// ==================================================
// field widths
// ==================================================

// byte address
`define SQ_ADDR_W 32
// one store data word
`define SQ_DATA_W 64
// rob index, shared with dispatch and commit
`define SQ_ROB_W 5

`endif
